/* hdl/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

`define XLEN         32
`define ARCH_REG_SZ  16
`define PHYS_REG_SZ  32
`define ROB_SZ       8
`define RS_SZ        4
`define MULT_STAGES  3
`define ZERO_REG     0

// derived widths
`define ARN_WIDTH    $clog2(`ARCH_REG_SZ)
`define PRN_WIDTH    $clog2(`PHYS_REG_SZ)
`define ROBN_WIDTH   $clog2(`ROB_SZ)
`define FREE_LIST_SZ (`PHYS_REG_SZ - `ARCH_REG_SZ)

`endif

/* hdl/ooo_pkg.sv */
`include "ooo_defines.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0]       data_t;
    typedef logic [`ARN_WIDTH-1:0]  arn_t;
    typedef logic [`PRN_WIDTH-1:0]  prn_t;
    typedef logic [`ROBN_WIDTH-1:0] robn_t;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_MUL
    } alu_func_e;

    typedef enum logic [1:0] {
        NO_ERROR,
        ILLEGAL_INST,
        HALTED
    } exc_e;

    typedef struct packed {
        logic      valid;
        fu_sel_e   fu;
        alu_func_e func;
        arn_t      opa_arn;
        arn_t      opb_arn;
        logic      use_imm;
        data_t     imm;
        arn_t      dest_arn;
        logic      illegal;
        logic      halt;
    } id_ooo_packet_t;

    typedef struct packed {
        logic [`XLEN-`PRN_WIDTH-1:0] pad;
        prn_t                        prn;
    } rs_tag_t;

    // value once ready, producer tag while waiting
    typedef union packed {
        data_t   value;
        rs_tag_t tag;
    } rs_operand_u;

    typedef struct packed {
        logic        valid;
        fu_sel_e     fu;
        alu_func_e   func;
        logic        op1_ready;
        rs_operand_u op1;
        logic        op2_ready;
        rs_operand_u op2;
        prn_t        dest_prn;
        robn_t       robn;
    } rs_entry_t;

    typedef struct packed {
        logic      valid;
        alu_func_e func;
        data_t     op1;
        data_t     op2;
        prn_t      dest_prn;
        robn_t     robn;
    } fu_packet_t;

    typedef struct packed {
        logic  valid;
        prn_t  dest_prn;
        robn_t robn;
        data_t value;
    } cdb_packet_t;

    typedef struct packed {
        prn_t op1_prn;
        prn_t op2_prn;
        prn_t dest_prn;
        prn_t old_prn;
    } rat_is_output_t;

    typedef struct packed {
        arn_t dest_arn;
        prn_t dest_prn;
        prn_t old_prn;
        logic executed;
        logic illegal;
        logic halt;
    } rob_entry_t;

    typedef struct packed {
        logic  valid;
        logic  wr_en;
        arn_t  wr_idx;
        data_t wr_data;
        exc_e  exception_code;
    } ooo_ct_packet_t;

endpackage

/* hdl/rat.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rat import ooo_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           rename_en,
    input  arn_t           opa_arn,
    input  arn_t           opb_arn,
    input  arn_t           dest_arn,
    output rat_is_output_t rat_is_output,
    input  logic           free_en,
    input  prn_t           free_prn,
    output logic           free_empty
);
    localparam int FL_PTR_W = $clog2(`FREE_LIST_SZ);

    prn_t                map       [`ARCH_REG_SZ];
    prn_t                free_list [`FREE_LIST_SZ];
    logic [FL_PTR_W-1:0] head;
    logic [FL_PTR_W-1:0] tail;
    logic [FL_PTR_W:0]   count;
    logic                pop;

    // zero register keeps prn 0
    assign pop        = rename_en && dest_arn != `ZERO_REG;
    assign free_empty = count == '0;

    always_comb begin
        rat_is_output.op1_prn  = map[opa_arn];
        rat_is_output.op2_prn  = map[opb_arn];
        rat_is_output.old_prn  = map[dest_arn];
        rat_is_output.dest_prn = (dest_arn == `ZERO_REG) ? prn_t'(0) : free_list[head];
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                map[i] <= prn_t'(i);
            end
            // all prns above the arch set start free
            for (int i = 0; i < `FREE_LIST_SZ; i++) begin
                free_list[i] <= prn_t'(`ARCH_REG_SZ + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (FL_PTR_W+1)'(`FREE_LIST_SZ);
        end else begin
            if (pop) begin
                map[dest_arn] <= free_list[head];
                head          <= head + 1'b1;
            end
            if (free_en) begin
                free_list[tail] <= free_prn;
                tail            <= tail + 1'b1;
            end
            count <= count + {{FL_PTR_W{1'b0}}, free_en} - {{FL_PTR_W{1'b0}}, pop};
        end
    end

endmodule

/* hdl/prf.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module prf import ooo_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,
    input  prn_t        [1:0] read_prn,
    output data_t       [1:0] read_value,
    output logic        [1:0] read_valid,
    input  logic              invalidate_en,
    input  prn_t              invalidate_prn,
    input  cdb_packet_t       cdb,
    input  prn_t              ct_prn,
    output data_t             ct_value
);
    data_t                   values [`PHYS_REG_SZ];
    logic [`PHYS_REG_SZ-1:0] valid;
    logic                    cdb_wr;

    // prn 0 backs the zero register and is never written
    assign cdb_wr   = cdb.valid && cdb.dest_prn != '0;
    assign ct_value = values[ct_prn];

    // same-cycle cdb result bypassed to rename reads
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (cdb_wr && cdb.dest_prn == read_prn[i]) begin
                read_value[i] = cdb.value;
                read_valid[i] = 1'b1;
            end else begin
                read_value[i] = values[read_prn[i]];
                read_valid[i] = valid[read_prn[i]];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `PHYS_REG_SZ; i++) begin
                values[i] <= '0;
                valid[i]  <= i < `ARCH_REG_SZ;
            end
        end else begin
            if (invalidate_en) begin
                valid[invalidate_prn] <= 1'b0;
            end
            if (cdb_wr) begin
                values[cdb.dest_prn] <= cdb.value;
                valid[cdb.dest_prn]  <= 1'b1;
            end
        end
    end

endmodule

/* hdl/rs.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rs import ooo_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        alloc_en,
    input  rs_entry_t   alloc_entry,
    input  cdb_packet_t cdb,
    input  logic        alu_avail,
    input  logic        mult_avail,
    output fu_packet_t  alu_packet,
    output fu_packet_t  mult_packet,
    output logic        full
);
    localparam int IDX_W = $clog2(`RS_SZ);

    rs_entry_t         entries [`RS_SZ];
    logic [IDX_W-1:0]  age     [`RS_SZ];
    logic [`RS_SZ-1:0] busy;
    logic [IDX_W-1:0]  alloc_idx;
    logic [IDX_W-1:0]  alu_idx;
    logic [IDX_W-1:0]  mult_idx;
    logic              alu_issue;
    logic              mult_issue;

    function automatic rs_entry_t wake(input rs_entry_t e, input cdb_packet_t c);
        rs_entry_t w;
        w = e;
        if (c.valid && !e.op1_ready && e.op1.tag.prn == c.dest_prn) begin
            w.op1_ready = 1'b1;
            w.op1.value = c.value;
        end
        if (c.valid && !e.op2_ready && e.op2.tag.prn == c.dest_prn) begin
            w.op2_ready = 1'b1;
            w.op2.value = c.value;
        end
        return w;
    endfunction

    // oldest ready entry for one unit, msb is the found flag
    function automatic logic [IDX_W:0] pick_oldest(input fu_sel_e fu);
        logic             found;
        logic [IDX_W-1:0] idx;
        found = 1'b0;
        idx   = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                    && entries[i].fu == fu && (!found || age[i] > age[idx])) begin
                found = 1'b1;
                idx   = IDX_W'(i);
            end
        end
        return {found, idx};
    endfunction

    // age is the count of younger valid entries
    function automatic logic [IDX_W-1:0] issued_younger(input int i);
        logic [IDX_W-1:0] n;
        n = '0;
        if (alu_issue && age[alu_idx] < age[i]) begin
            n = n + 1'b1;
        end
        if (mult_issue && age[mult_idx] < age[i]) begin
            n = n + 1'b1;
        end
        return n;
    endfunction

    function automatic fu_packet_t to_fu(input rs_entry_t e, input logic v);
        fu_packet_t p;
        p.valid    = v;
        p.func     = e.func;
        p.op1      = e.op1.value;
        p.op2      = e.op2.value;
        p.dest_prn = e.dest_prn;
        p.robn     = e.robn;
        return p;
    endfunction

    always_comb begin
        alloc_idx = '0;
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            busy[i] = entries[i].valid;
            if (!entries[i].valid) begin
                alloc_idx = IDX_W'(i);
            end
        end
        {alu_issue, alu_idx}   = pick_oldest(FU_ALU);
        {mult_issue, mult_idx} = pick_oldest(FU_MULT);
        alu_issue   = alu_issue && alu_avail;
        mult_issue  = mult_issue && mult_avail;
        alu_packet  = to_fu(entries[alu_idx], alu_issue);
        mult_packet = to_fu(entries[mult_idx], mult_issue);
    end

    assign full = &busy;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `RS_SZ; i++) begin
                entries[i].valid <= 1'b0;
                age[i]           <= '0;
            end
        end else begin
            for (int i = 0; i < `RS_SZ; i++) begin
                if (entries[i].valid) begin
                    entries[i] <= wake(entries[i], cdb);
                    age[i]     <= age[i] + IDX_W'(alloc_en) - issued_younger(i);
                end
                if ((alu_issue && alu_idx == IDX_W'(i)) ||
                        (mult_issue && mult_idx == IDX_W'(i))) begin
                    entries[i].valid <= 1'b0;
                end
                if (alloc_en && alloc_idx == IDX_W'(i)) begin
                    entries[i] <= wake(alloc_entry, cdb);
                    age[i]     <= '0;
                end
            end
        end
    end

endmodule

/* hdl/fu_cdb.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module fu_cdb import ooo_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  fu_packet_t  alu_packet,
    input  fu_packet_t  mult_packet,
    output logic        alu_avail,
    output logic        mult_avail,
    output cdb_packet_t cdb
);
    localparam int SHAMT_W = $clog2(`XLEN);

    cdb_packet_t alu_result;
    cdb_packet_t mult_pipe [`MULT_STAGES];
    cdb_packet_t mult_out;

    function automatic data_t alu_compute(input fu_packet_t p);
        case (p.func)
            ALU_ADD: return p.op1 + p.op2;
            ALU_SUB: return p.op1 - p.op2;
            ALU_AND: return p.op1 & p.op2;
            ALU_OR:  return p.op1 | p.op2;
            ALU_XOR: return p.op1 ^ p.op2;
            ALU_SLL: return p.op1 << p.op2[SHAMT_W-1:0];
            ALU_SRL: return p.op1 >> p.op2[SHAMT_W-1:0];
            ALU_SLT: return {{(`XLEN-1){1'b0}}, $signed(p.op1) < $signed(p.op2)};
            default: return p.op1 * p.op2;
        endcase
    endfunction

    function automatic cdb_packet_t to_cdb(input fu_packet_t p, input data_t value);
        cdb_packet_t c;
        c.valid    = p.valid;
        c.dest_prn = p.dest_prn;
        c.robn     = p.robn;
        c.value    = value;
        return c;
    endfunction

    assign mult_out = mult_pipe[`MULT_STAGES-1];

    // multiplier owns the bus, alu result waits in its register
    assign cdb        = mult_out.valid ? mult_out : alu_result;
    assign alu_avail  = !alu_result.valid || !mult_out.valid;
    assign mult_avail = 1'b1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            alu_result.valid <= 1'b0;
        end else if (alu_avail) begin
            alu_result <= to_cdb(alu_packet, alu_compute(alu_packet));
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `MULT_STAGES; i++) begin
                mult_pipe[i].valid <= 1'b0;
            end
        end else begin
            mult_pipe[0] <= to_cdb(mult_packet, mult_packet.op1 * mult_packet.op2);
            for (int i = 1; i < `MULT_STAGES; i++) begin
                mult_pipe[i] <= mult_pipe[i-1];
            end
        end
    end

endmodule

/* hdl/rob.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rob import ooo_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        alloc_en,
    input  rob_entry_t  alloc_entry,
    output robn_t       tail,
    input  cdb_packet_t cdb,
    output rob_entry_t  head_entry,
    output logic        commit,
    output logic        full,
    output logic        halted
);
    rob_entry_t            entries [`ROB_SZ];
    robn_t                 head;
    logic [`ROBN_WIDTH:0]  count;

    assign head_entry = entries[head];
    assign full       = count == `ROB_SZ;
    // nothing retires once a halt has gone out
    assign commit     = count != '0 && entries[head].executed && !halted;

    always_ff @(posedge clock) begin
        if (cdb.valid) begin
            entries[cdb.robn].executed <= 1'b1;
        end
        if (alloc_en) begin
            entries[tail] <= alloc_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            halted <= 1'b0;
        end else begin
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (commit) begin
                head <= head + 1'b1;
                if (head_entry.halt || head_entry.illegal) begin
                    halted <= 1'b1;
                end
            end
            count <= count + {{`ROBN_WIDTH{1'b0}}, alloc_en}
                           - {{`ROBN_WIDTH{1'b0}}, commit};
        end
    end

endmodule

/* hdl/ooo.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo import ooo_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  id_ooo_packet_t id_ooo_packet,
    output logic           structural_hazard,
    output ooo_ct_packet_t ooo_ct_packet
);
    logic           accept;
    logic           no_exec;
    arn_t           dest_arn;
    logic           rs_full;
    logic           rob_full;
    logic           free_empty;
    logic           halted;
    logic           commit;
    logic           alu_avail;
    logic           mult_avail;
    logic           op1_ready;
    logic           op2_ready;
    logic           ct_wr_en;
    rat_is_output_t rat_is_output;
    prn_t     [1:0] read_prn;
    data_t    [1:0] read_value;
    logic     [1:0] read_valid;
    data_t          op2_value;
    cdb_packet_t    cdb;
    rs_entry_t      rs_entry;
    rob_entry_t     rob_entry;
    rob_entry_t     head_entry;
    robn_t          rob_tail;
    fu_packet_t     alu_packet;
    fu_packet_t     mult_packet;
    data_t          ct_value;

    function automatic rs_operand_u make_operand(input logic ready, input data_t value,
                                                 input prn_t prn);
        rs_operand_u op;
        op.value = value;
        if (!ready) begin
            op.tag.pad = '0;
            op.tag.prn = prn;
        end
        return op;
    endfunction

    assign structural_hazard = rs_full || rob_full || free_empty || halted;
    assign accept            = id_ooo_packet.valid && !structural_hazard;

    // halt and illegal go straight to the rob and write nothing
    assign no_exec  = id_ooo_packet.halt || id_ooo_packet.illegal;
    assign dest_arn = no_exec ? arn_t'(`ZERO_REG) : id_ooo_packet.dest_arn;
    assign read_prn = {rat_is_output.op2_prn, rat_is_output.op1_prn};

    always_comb begin
        op1_ready = id_ooo_packet.opa_arn == `ZERO_REG || read_valid[0];
        op2_ready = id_ooo_packet.use_imm || id_ooo_packet.opb_arn == `ZERO_REG
                    || read_valid[1];
        op2_value = id_ooo_packet.use_imm ? id_ooo_packet.imm : read_value[1];
        if (!id_ooo_packet.use_imm && id_ooo_packet.opb_arn == `ZERO_REG) begin
            op2_value = '0;
        end

        rs_entry.valid     = 1'b1;
        rs_entry.fu        = id_ooo_packet.fu;
        rs_entry.func      = id_ooo_packet.func;
        rs_entry.op1_ready = op1_ready;
        rs_entry.op1       = make_operand(op1_ready,
                                          id_ooo_packet.opa_arn == `ZERO_REG ? '0 : read_value[0],
                                          rat_is_output.op1_prn);
        rs_entry.op2_ready = op2_ready;
        rs_entry.op2       = make_operand(op2_ready, op2_value, rat_is_output.op2_prn);
        rs_entry.dest_prn  = rat_is_output.dest_prn;
        rs_entry.robn      = rob_tail;

        rob_entry.dest_arn = dest_arn;
        rob_entry.dest_prn = rat_is_output.dest_prn;
        rob_entry.old_prn  = rat_is_output.old_prn;
        rob_entry.executed = no_exec;
        rob_entry.illegal  = id_ooo_packet.illegal;
        rob_entry.halt     = id_ooo_packet.halt;
    end

    // commit side
    assign ct_wr_en = head_entry.dest_arn != `ZERO_REG;

    always_comb begin
        ooo_ct_packet.valid   = commit;
        ooo_ct_packet.wr_en   = commit && ct_wr_en;
        ooo_ct_packet.wr_idx  = head_entry.dest_arn;
        ooo_ct_packet.wr_data = ct_value;
        ooo_ct_packet.exception_code = head_entry.illegal ? ILLEGAL_INST :
                                       head_entry.halt    ? HALTED : NO_ERROR;
    end

    rat rat0 (
        .clock(clock),
        .rst_n(rst_n),
        .rename_en(accept),
        .opa_arn(id_ooo_packet.opa_arn),
        .opb_arn(id_ooo_packet.opb_arn),
        .dest_arn(dest_arn),
        .rat_is_output(rat_is_output),
        .free_en(commit && ct_wr_en),
        .free_prn(head_entry.old_prn),
        .free_empty(free_empty)
    );

    prf prf0 (
        .clock(clock),
        .rst_n(rst_n),
        .read_prn(read_prn),
        .read_value(read_value),
        .read_valid(read_valid),
        .invalidate_en(accept && dest_arn != `ZERO_REG),
        .invalidate_prn(rat_is_output.dest_prn),
        .cdb(cdb),
        .ct_prn(head_entry.dest_prn),
        .ct_value(ct_value)
    );

    rs rs0 (
        .clock(clock),
        .rst_n(rst_n),
        .alloc_en(accept && !no_exec),
        .alloc_entry(rs_entry),
        .cdb(cdb),
        .alu_avail(alu_avail),
        .mult_avail(mult_avail),
        .alu_packet(alu_packet),
        .mult_packet(mult_packet),
        .full(rs_full)
    );

    fu_cdb fu_cdb0 (
        .clock(clock),
        .rst_n(rst_n),
        .alu_packet(alu_packet),
        .mult_packet(mult_packet),
        .alu_avail(alu_avail),
        .mult_avail(mult_avail),
        .cdb(cdb)
    );

    rob rob0 (
        .clock(clock),
        .rst_n(rst_n),
        .alloc_en(accept),
        .alloc_entry(rob_entry),
        .tail(rob_tail),
        .cdb(cdb),
        .head_entry(head_entry),
        .commit(commit),
        .full(rob_full),
        .halted(halted)
    );

endmodule

/* bench/ooo_tb.sv */
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_tb import ooo_pkg::*; ();

    localparam int TIMEOUT = 400;

    logic           clock;
    logic           rst_n;
    id_ooo_packet_t id_ooo_packet;
    logic           structural_hazard;
    ooo_ct_packet_t ooo_ct_packet;

    data_t          arch_regs [`ARCH_REG_SZ];
    ooo_ct_packet_t exp_q [$];
    int             seed;
    int             errors;
    int             commits;
    int             accepted;
    int             tests;
    bit             accepted_any;
    bit             halt_seen;
    bit             hazard_seen;
    bit             timed_out;

    ooo dut0 (
        .clock(clock),
        .rst_n(rst_n),
        .id_ooo_packet(id_ooo_packet),
        .structural_hazard(structural_hazard),
        .ooo_ct_packet(ooo_ct_packet)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // quiet outputs between reset and the first instruction
    assert property (@(posedge clock) disable iff (!rst_n)
            !accepted_any |-> !ooo_ct_packet.valid && !structural_hazard)
        else begin
            errors++;
            $display("commit or structural_hazard seen before the first instruction");
        end

    always @(posedge clock) begin
        if (!rst_n) begin
            halt_seen <= 1'b0;
        end else if (ooo_ct_packet.valid && ooo_ct_packet.exception_code != NO_ERROR) begin
            halt_seen <= 1'b1;
        end
    end

    // once halted, no commit and back-pressure held
    assert property (@(posedge clock) disable iff (!rst_n)
            halt_seen |-> !ooo_ct_packet.valid && structural_hazard)
        else begin
            errors++;
            $display("commit after a halt, or structural_hazard dropped after a halt");
        end

    always @(negedge clock) begin
        ooo_ct_packet_t want;
        if (rst_n && ooo_ct_packet.valid) begin
            commits++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("commit with no instruction outstanding, wr_idx %h",
                         ooo_ct_packet.wr_idx);
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (ooo_ct_packet.exception_code == want.exception_code) else begin
                    errors++;
                    $display("error exception_code: got %h expected %h",
                             ooo_ct_packet.exception_code, want.exception_code);
                end
                assert (ooo_ct_packet.wr_en == want.wr_en) else begin
                    errors++;
                    $display("error wr_en: got %h expected %h",
                             ooo_ct_packet.wr_en, want.wr_en);
                end
                assert (want.exception_code != NO_ERROR
                        || ooo_ct_packet.wr_idx == want.wr_idx) else begin
                    errors++;
                    $display("error wr_idx: got %h expected %h",
                             ooo_ct_packet.wr_idx, want.wr_idx);
                end
                assert (!want.wr_en || ooo_ct_packet.wr_data == want.wr_data) else begin
                    errors++;
                    $display("error wr_data: got %h expected %h (wr_idx %h)",
                             ooo_ct_packet.wr_data, want.wr_data, want.wr_idx);
                end
            end
        end
    end

    function automatic id_ooo_packet_t reg_op(input alu_func_e f, input arn_t d,
                                              input arn_t a, input arn_t b);
        id_ooo_packet_t p;
        p          = '0;
        p.valid    = 1'b1;
        p.fu       = (f == ALU_MUL) ? FU_MULT : FU_ALU;
        p.func     = f;
        p.dest_arn = d;
        p.opa_arn  = a;
        p.opb_arn  = b;
        return p;
    endfunction

    function automatic id_ooo_packet_t imm_op(input alu_func_e f, input arn_t d,
                                              input arn_t a, input data_t imm);
        id_ooo_packet_t p;
        p         = reg_op(f, d, a, '0);
        p.use_imm = 1'b1;
        p.imm     = imm;
        return p;
    endfunction

    // mul weighted up so chains stall the RS
    function automatic id_ooo_packet_t random_op();
        alu_func_e f;
        arn_t      d;
        arn_t      a;
        f = (($random(seed) & 3) == 0) ? ALU_MUL : alu_func_e'($unsigned($random(seed)) % 8);
        d = arn_t'($random(seed) & 15);
        a = arn_t'($random(seed) & 15);
        if ($random(seed) & 1) begin
            return imm_op(f, d, a, data_t'($random(seed)));
        end
        return reg_op(f, d, a, arn_t'($random(seed) & 15));
    endfunction

    function automatic data_t ref_result(input id_ooo_packet_t p);
        data_t a;
        data_t b;
        a = arch_regs[p.opa_arn];
        b = p.use_imm ? p.imm : arch_regs[p.opb_arn];
        case (p.func)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a * b;
        endcase
    endfunction

    task automatic model_step(input id_ooo_packet_t p);
        ooo_ct_packet_t c;
        c.valid          = 1'b1;
        c.wr_idx         = p.dest_arn;
        c.wr_en          = !(p.illegal || p.halt) && p.dest_arn != `ZERO_REG;
        c.wr_data        = ref_result(p);
        c.exception_code = p.illegal ? ILLEGAL_INST : (p.halt ? HALTED : NO_ERROR);
        if (c.wr_en) begin
            arch_regs[p.dest_arn] = c.wr_data;
        end
        exp_q.push_back(c);
    endtask

    // 8 cycles of reset, model registers cleared with it
    task automatic apply_reset();
        rst_n         = 1'b0;
        id_ooo_packet = '0;
        accepted_any  = 1'b0;
        for (int i = 0; i < `ARCH_REG_SZ; i++) begin
            arch_regs[i] = '0;
        end
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d commits checked, %0d errors", tests, commits, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string why);
        $display("timeout: %s", why);
        timed_out = 1'b1;
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send(input id_ooo_packet_t p, input bit track);
        int waited;
        waited = 0;
        if (timed_out) begin
            return;
        end
        id_ooo_packet       = p;
        id_ooo_packet.valid = 1'b1;
        @(negedge clock);
        while (structural_hazard) begin
            hazard_seen = 1'b1;
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("instruction held back by structural_hazard too long");
                id_ooo_packet.valid = 1'b0;
                return;
            end
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        id_ooo_packet.valid = 1'b0;
        accepted_any        = 1'b1;
        accepted++;
        if (track) begin
            model_step(p);
        end
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout({what, " never finished committing"});
            end else begin
                @(posedge clock);
                #1;
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    endtask

    initial begin
        int             e0;
        int             a0;
        int             c0;
        id_ooo_packet_t p;
        seed     = 32'he873_3dcd;
        errors   = 0;
        commits  = 0;
        accepted = 0;
        tests    = 0;
        apply_reset();

        e0 = errors;
        repeat (10) @(posedge clock);
        #1;
        end_test("idle after reset", e0);

        e0 = errors;
        send(imm_op(ALU_ADD, 1, 0, 32'd3), 1);
        send(imm_op(ALU_ADD, 2, 0, 32'd5), 1);
        send(imm_op(ALU_ADD, 3, 0, 32'hffff_fff0), 1);
        send(imm_op(ALU_OR, 5, 6, 32'h0000_f0f0), 1);
        send(reg_op(ALU_AND, 7, 8, 9), 1);
        send(imm_op(ALU_XOR, 10, 11, 32'h1234_5678), 1);
        send(imm_op(ALU_SLL, 12, 0, 32'd4), 1);
        send(reg_op(ALU_SUB, 4, 13, 14), 1);
        drain("independent alu ops");
        end_test("independent alu ops", e0);

        // mul chains with alu ops landing on the same cdb cycle
        e0 = errors;
        send(reg_op(ALU_MUL, 6, 1, 2), 1);
        send(reg_op(ALU_MUL, 7, 6, 3), 1);
        send(reg_op(ALU_ADD, 8, 7, 1), 1);
        send(reg_op(ALU_MUL, 9, 2, 2), 1);
        send(reg_op(ALU_MUL, 11, 10, 1), 1);
        send(reg_op(ALU_MUL, 12, 5, 2), 1);
        send(imm_op(ALU_ADD, 13, 1, 32'd1), 1);
        send(reg_op(ALU_SUB, 14, 9, 11), 1);
        send(reg_op(ALU_SLT, 15, 3, 1), 1);
        send(reg_op(ALU_SRL, 6, 10, 1), 1);
        send(reg_op(ALU_XOR, 8, 8, 14), 1);
        drain("dependent mul and alu chains");
        end_test("dependent mul and alu chains", e0);

        e0          = errors;
        a0          = accepted;
        c0          = commits;
        hazard_seen = 1'b0;
        for (int i = 0; i < 300; i++) begin
            send(random_op(), 1);
        end
        drain("random stream");
        assert (commits - c0 == accepted - a0) else begin
            errors++;
            $display("error commit count: got %h expected %h", commits - c0, accepted - a0);
        end
        assert (hazard_seen) else begin
            errors++;
            $display("structural_hazard never rose during the random stream");
        end
        end_test("random stream", e0);

        e0 = errors;
        send(imm_op(ALU_ADD, 0, 1, 32'd7), 1);
        send(reg_op(ALU_MUL, 0, 2, 2), 1);
        send(imm_op(ALU_ADD, 4, 0, 32'd0), 1);
        send(reg_op(ALU_OR, 5, 0, 0), 1);
        drain("zero register writes");
        end_test("zero register writes", e0);

        e0 = errors;
        send(imm_op(ALU_ADD, 1, 1, 32'd1), 1);
        send(reg_op(ALU_MUL, 2, 1, 1), 1);
        p      = imm_op(ALU_ADD, 3, 0, 32'd9);
        p.halt = 1'b1;
        send(p, 1);
        // younger than the halt, must never retire
        send(imm_op(ALU_ADD, 4, 0, 32'd1), 0);
        drain("halt sequence");
        repeat (40) @(posedge clock);
        #1;
        assert (structural_hazard) else begin
            errors++;
            $display("structural_hazard low after the halt committed");
        end
        end_test("halt", e0);

        // fresh core for the illegal case
        apply_reset();
        e0 = errors;
        send(imm_op(ALU_ADD, 1, 0, 32'd2), 1);
        send(reg_op(ALU_MUL, 2, 1, 1), 1);
        p         = reg_op(ALU_ADD, 3, 2, 1);
        p.illegal = 1'b1;
        send(p, 1);
        send(imm_op(ALU_ADD, 4, 1, 32'd1), 0);
        drain("illegal sequence");
        repeat (20) @(posedge clock);
        #1;
        end_test("illegal instruction", e0);

        finish_run();
    end

endmodule

/* vlog.f */
+incdir+hdl
hdl/ooo_pkg.sv
hdl/rat.sv
hdl/prf.sv
hdl/rs.sv
hdl/fu_cdb.sv
hdl/rob.sv
hdl/ooo.sv
bench/ooo_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_tb \
		-f vlog.f -Mdir obj_dir -o ooo_tb

run: build
	./obj_dir/ooo_tb | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
